// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuTb -f verilog.f -o cpuSim

output=$(./obj_dir/cpuSim)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi

// ==== tests/cpuTb.sv ====
/*
 * Testbench for the pipelined RV32I subset core. Loads a program and
 * the expected stores from a data file, models both memories and
 * checks every store the core makes.
 */
`timescale 1ns/10ps
`default_nettype none

module cpuTb;

    localparam logic [31:0] ResetVector = 32'h0040_0000;
    localparam logic [31:0] Nop         = 32'h0000_0013;   // addi x0, x0, 0

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] readData;
    logic [31:0] pc;
    logic [31:0] aluResult;
    logic [31:0] writeData;
    logic        memWrite;

    logic [31:0]  imem [256];
    logic [31:0]  dmem [256];
    int           nInstr;

    logic [31:0]  expAddr [$];
    logic [31:0]  expData [$];
    int           expTest [$];
    logic [127:0] testName [16];
    int           testErrors [16];
    int           testStoresLeft [16];
    int           nTests;

    int testsPassed;
    int testsFailed;
    int storesChecked;
    int extraStores;
    int resetErrors;
    int fileErrors;
    int cycles;
    int limit = 10000;

    riscvCpu #(.ResetVector(ResetVector)) dut (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .aluResult (aluResult),
        .writeData (writeData),
        .memWrite  (memWrite)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - ResetVector) >> 2;
        if (addr < ResetVector || idx >= 32'(nInstr))
            return Nop;   // past the program
        return imem[idx[7:0]];
    endfunction

    task automatic reportTest(input int t);
        if (testErrors[t] == 0)
        begin
            testsPassed++;
            $display("%0s: ok", testName[t]);
        end
        else
        begin
            testsFailed++;
            $display("%0s: FAILED with %0d errors", testName[t], testErrors[t]);
        end
    endtask

    task automatic checkStore;
        int          t;
        logic [31:0] a;
        logic [31:0] d;
        if (rst || !memWrite)
            return;
        dmem[aluResult[9:2]] = writeData;
        if (expAddr.size() == 0)
        begin
            $display("Unexpected store of %h to address %h at %0t", writeData, aluResult, $time);
            extraStores++;
            return;
        end
        t = expTest.pop_front();
        a = expAddr.pop_front();
        d = expData.pop_front();
        assert (aluResult == a && writeData == d)
        else
        begin
            $display("Mismatch at %0t: store of %h to %h, expected %h to %h",
                     $time, writeData, aluResult, d, a);
            testErrors[t]++;
        end
        storesChecked++;
        testStoresLeft[t]--;
        if (testStoresLeft[t] == 0)
            reportTest(t);
    endtask

    task automatic loadProgram;
        int           fd;
        logic [7:0]   tag;
        logic [1023:0] line;
        logic [31:0]  a;
        logic [31:0]  d;
        int           code;
        fd = $fopen("tests/programInput.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open tests/programInput.txt");
            fileErrors++;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1)
        begin
            if (tag == "#")
                code = $fgets(line, fd);   // comment line
            else if (tag == "T")
            begin
                code = $fscanf(fd, "%s", testName[nTests]);
                if (code != 1)
                    fileErrors++;
                nTests++;
            end
            else if (tag == "I")
            begin
                code = $fscanf(fd, "%h", d);
                if (code != 1)
                    fileErrors++;
                imem[nInstr] = d;
                nInstr++;
            end
            else if (tag == "S")
            begin
                code = $fscanf(fd, "%h %h", a, d);
                if (code != 2)
                    fileErrors++;
                expAddr.push_back(a);
                expData.push_back(d);
                expTest.push_back(nTests - 1);
                testStoresLeft[nTests - 1]++;
            end
        end
        if (fileErrors > 0)
            $display("Malformed lines in tests/programInput.txt");
        $fclose(fd);
    endtask

    // check stores at the edge and drive inputs just after
    always @(posedge clk)
    begin
        checkStore();
        #1;
        instr    = fetchWord(pc);
        readData = dmem[aluResult[9:2]];
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("Timeout: program did not finish within %0d cycles", limit);
            $display("test failed");
            $finish;
        end
    end

    initial
    begin
        int t;
        rst      = 1'b1;
        instr    = Nop;
        readData = '0;
        for (int i = 0; i < 256; i++)
        begin
            dmem[i] = '0;
        end
        loadProgram();
        limit = 16 + 4 * nInstr + 50;

        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        assert (pc == ResetVector && memWrite == 1'b0)
        else
        begin
            $display("Mismatch at %0t: after reset pc %h memWrite %b", $time, pc, memWrite);
            resetErrors++;
        end
        if (resetErrors == 0)
        begin
            testsPassed++;
            $display("reset: ok");
        end
        else
        begin
            testsFailed++;
            $display("reset: FAILED with %0d errors", resetErrors);
        end

        // last instruction has left writeback
        while (pc < ResetVector + 32'(4 * (nInstr + 4)))
            @(posedge clk);

        while (expAddr.size() > 0)
        begin
            t = expTest.pop_front();
            $display("Missing store: %h to address %h never happened",
                     expData.pop_front(), expAddr.pop_front());
            testErrors[t]++;
            testStoresLeft[t]--;
            if (testStoresLeft[t] == 0)
                reportTest(t);
        end

        $display("%0d passed, %0d failed, %0d stores checked, %0d unexpected stores",
                 testsPassed, testsFailed, storesChecked, extraStores);
        if (testsFailed == 0 && extraStores == 0 && fileErrors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule : cpuTb

`default_nettype wire

// ==== tests/cpu_properties.sv ====
/*
 * Concurrent checks on reset behavior and pc sequencing, bound
 * into the core top level.
 */
`timescale 1ns/10ps
`default_nettype none

module cpuProperties #(
    parameter logic [31:0] ResetVector = 32'h0040_0000
) (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic [31:0] pc,
    input wire logic        memWrite,
    input wire logic        pcSrc
);

    noStoreInReset: assert property (@(posedge clk) rst |=> !memWrite)
        else $error("memWrite high during or right after reset");

    pcAtResetVector: assert property (@(posedge clk) $fell(rst) |-> pc == ResetVector)
        else $error("pc not at reset vector after reset");

    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    pcSequential: assert property (@(posedge clk) disable iff (rst)
                                   !pcSrc |=> pc == $past(pc) + 32'd4)
        else $error("pc did not advance by 4");

endmodule : cpuProperties

bind riscvCpu cpuProperties #(.ResetVector(ResetVector)) props (
    .clk      (clk),
    .rst      (rst),
    .pc       (pc),
    .memWrite (memWrite),
    .pcSrc    (pcSrc)
);

`default_nettype wire

// ==== tests/programInput.txt ====
# I <instruction word> | S <store address> <store data> | T <test name>
# stores are expected in the order listed
T arith
I 00500093
I FFD00113
I 00C00193
I 00000013
I 00208233
I 402082B3
I 0030F333
I 0030E3B3
I 00112433
I 00A10513
I 0061F593
I 00116613
I FFE12693
I 00402023
I 00502223
I 00602423
I 00702623
I 00802823
I 00A02A23
I 00B02C23
I 00C02E23
I 02D02023
S 00000000 00000002
S 00000004 00000008
S 00000008 00000004
S 0000000C 0000000D
S 00000010 00000001
S 00000014 00000007
S 00000018 00000004
S 0000001C FFFFFFFD
S 00000020 00000001
T loadStore
I 04102023
I 04002703
I 00000013
I 00000013
I 00170713
I 00000013
I 00000013
I 04E02223
S 00000040 00000005
S 00000044 00000006
T branch
I 00108863
I 04102423
I 04202623
I 04302823
I 04402A23
I 00208863
I 04502C23
I 04602E23
I 06702023
S 00000048 00000005
S 0000004C FFFFFFFD
S 00000054 00000002
S 00000058 00000008
S 0000005C 00000004
S 00000060 0000000D
T jump
I 0100086F
I 06102223
I 06202423
I 06302623
I 07002823
S 00000064 00000005
S 00000068 FFFFFFFD
S 00000070 004000A0
T zeroReg
I 00900013
I 00000013
I 00000013
I 06002A23
S 00000074 00000000

// ==== verilog.f ====
verilog/cpuPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/executeStage.sv
verilog/writebackStage.sv
verilog/riscvCpu.sv
tests/cpu_properties.sv
tests/cpuTb.sv

// ==== verilog/cpuPkg.sv ====
/*
 * Shared definitions for the five-stage RV32I subset core:
 * widths, opcode and control encodings, pipeline register bundles.
 */
`default_nettype none

package cpuPkg;

    localparam int Xlen     = 32;
    localparam int RegAddrW = 5;

    typedef logic [Xlen-1:0]     wordT;
    typedef logic [RegAddrW-1:0] regAddrT;

    typedef enum logic [6:0] {
        Load   = 7'd3,
        OpImm  = 7'd19,
        Store  = 7'd35,
        OpReg  = 7'd51,
        Branch = 7'd99,
        Jal    = 7'd111
    } opcodeE;

    typedef enum logic [2:0] {
        AluAdd = 3'b000,
        AluSub = 3'b001,
        AluAnd = 3'b010,
        AluOr  = 3'b011,
        AluSlt = 3'b101
    } aluCtrlE;

    typedef enum logic [1:0] {
        ResAlu     = 2'd0,
        ResMem     = 2'd1,
        ResPcPlus4 = 2'd2
    } resultSrcE;

    typedef enum logic [1:0] {
        ImmI = 2'd0,
        ImmS = 2'd1,
        ImmB = 2'd2,
        ImmJ = 2'd3
    } immSrcE;

    typedef struct packed {
        logic      regWrite;
        resultSrcE resultSrc;
        logic      memWrite;
        logic      jump;
        logic      branch;
        aluCtrlE   aluCtrl;
        logic      aluSrc;   // 1 selects the immediate
    } ctrlT;

    typedef struct packed {
        wordT pc;
        wordT pcPlus4;
        wordT instr;
    } fetchDecT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    rd1;
        wordT    rd2;
        wordT    pc;
        wordT    pcPlus4;
        regAddrT rd;
        wordT    immExt;
    } decExT;

    typedef struct packed {
        logic      regWrite;
        resultSrcE resultSrc;
        logic      memWrite;
        wordT      aluResult;
        wordT      writeData;
        regAddrT   rd;
        wordT      pcPlus4;
    } exMemT;

    typedef struct packed {
        logic      regWrite;
        resultSrcE resultSrc;
        wordT      aluResult;
        wordT      readData;
        regAddrT   rd;
        wordT      pcPlus4;
    } memWbT;

endpackage : cpuPkg

`default_nettype wire

// ==== verilog/decodeStage.sv ====
/*
 * Decode stage: main decoder, ALU decoder and immediate extension,
 * followed by the decode-to-execute pipeline register.
 */
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire cpuPkg::fetchDecT fetchDec,
    output cpuPkg::regAddrT       rs1Addr,
    output cpuPkg::regAddrT       rs2Addr,
    input  wire cpuPkg::wordT     rs1Data,
    input  wire cpuPkg::wordT     rs2Data,
    output cpuPkg::decExT         decEx
);

    cpuPkg::wordT    instr;
    cpuPkg::opcodeE  op;
    logic [2:0]      funct3;
    logic            funct7b5;
    logic [1:0]      aluOp;        // 00 add, 01 sub, 10 by funct3
    cpuPkg::immSrcE  immSrc;
    cpuPkg::ctrlT    ctrl;
    cpuPkg::wordT    immExt;

    assign instr    = fetchDec.instr;
    assign op       = cpuPkg::opcodeE'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    assign rs1Addr  = instr[19:15];
    assign rs2Addr  = instr[24:20];

    // main decoder
    always_comb
    begin
        ctrl   = '0;
        aluOp  = 2'b00;
        immSrc = cpuPkg::ImmI;
        case (op)
            cpuPkg::Load:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = cpuPkg::ResMem;
                ctrl.aluSrc    = 1'b1;
            end
            cpuPkg::Store:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                immSrc        = cpuPkg::ImmS;
            end
            cpuPkg::OpReg:
            begin
                ctrl.regWrite = 1'b1;
                aluOp         = 2'b10;
            end
            cpuPkg::OpImm:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                aluOp         = 2'b10;
            end
            cpuPkg::Branch:
            begin
                ctrl.branch = 1'b1;
                aluOp       = 2'b01;   // compare by subtraction
                immSrc      = cpuPkg::ImmB;
            end
            cpuPkg::Jal:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = cpuPkg::ResPcPlus4;
                ctrl.jump      = 1'b1;
                immSrc         = cpuPkg::ImmJ;
            end
            default: ctrl = '0;
        endcase

        // alu decoder
        case (aluOp)
            2'b00: ctrl.aluCtrl = cpuPkg::AluAdd;
            2'b01: ctrl.aluCtrl = cpuPkg::AluSub;
            default:
            begin
                case (funct3)
                    3'b000:  ctrl.aluCtrl = (instr[5] && funct7b5) ? cpuPkg::AluSub
                                                                   : cpuPkg::AluAdd;
                    3'b010:  ctrl.aluCtrl = cpuPkg::AluSlt;
                    3'b110:  ctrl.aluCtrl = cpuPkg::AluOr;
                    3'b111:  ctrl.aluCtrl = cpuPkg::AluAnd;
                    default: ctrl.aluCtrl = cpuPkg::AluAdd;
                endcase
            end
        endcase
    end

    // sign extension per format
    always_comb
    begin
        case (immSrc)
            cpuPkg::ImmI: immExt = {{20{instr[31]}}, instr[31:20]};
            cpuPkg::ImmS: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            cpuPkg::ImmB: immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default:      immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            decEx <= '0;
        end
        else
        begin
            decEx.ctrl    <= ctrl;
            decEx.rd1     <= rs1Data;
            decEx.rd2     <= rs2Data;
            decEx.pc      <= fetchDec.pc;
            decEx.pcPlus4 <= fetchDec.pcPlus4;
            decEx.rd      <= instr[11:7];
            decEx.immExt  <= immExt;
        end
    end

endmodule : decodeStage

`default_nettype wire

// ==== verilog/executeStage.sv ====
/*
 * Execute stage: operand select, ALU, branch target and taken
 * decision, then the execute-to-memory pipeline register.
 */
`timescale 1ns/10ps
`default_nettype none

module executeStage (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire cpuPkg::decExT decEx,
    output logic               pcSrc,
    output cpuPkg::wordT       pcTarget,
    output cpuPkg::exMemT      exMem
);

    cpuPkg::wordT srcA;
    cpuPkg::wordT srcB;
    cpuPkg::wordT aluResult;
    logic         zero;

    assign srcA = decEx.rd1;
    assign srcB = decEx.ctrl.aluSrc ? decEx.immExt : decEx.rd2;

    always_comb
    begin
        case (decEx.ctrl.aluCtrl)
            cpuPkg::AluAdd: aluResult = srcA + srcB;
            cpuPkg::AluSub: aluResult = srcA - srcB;
            cpuPkg::AluAnd: aluResult = srcA & srcB;
            cpuPkg::AluOr:  aluResult = srcA | srcB;
            cpuPkg::AluSlt: aluResult = {31'd0, $signed(srcA) < $signed(srcB)};
            default:        aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // beq and jal both target pc + imm
    assign pcTarget = decEx.pc + decEx.immExt;
    assign pcSrc    = (decEx.ctrl.branch && zero) || decEx.ctrl.jump;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            exMem <= '0;
        end
        else
        begin
            exMem.regWrite  <= decEx.ctrl.regWrite;
            exMem.resultSrc <= decEx.ctrl.resultSrc;
            exMem.memWrite  <= decEx.ctrl.memWrite;
            exMem.aluResult <= aluResult;
            exMem.writeData <= decEx.rd2;   // store data is rs2
            exMem.rd        <= decEx.rd;
            exMem.pcPlus4   <= decEx.pcPlus4;
        end
    end

endmodule : executeStage

`default_nettype wire

// ==== verilog/fetchStage.sv ====
/*
 * Fetch stage: program counter with branch redirect and the
 * fetch-to-decode pipeline register.
 */
`timescale 1ns/10ps
`default_nettype none

module fetchStage #(
    parameter cpuPkg::wordT ResetVector = 32'h0040_0000
) (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire cpuPkg::wordT instr,
    input  wire logic         pcSrc,
    input  wire cpuPkg::wordT pcTarget,
    output cpuPkg::wordT      pc,
    output cpuPkg::fetchDecT  fetchDec
);

    cpuPkg::wordT pcPlus4;

    assign pcPlus4 = pc + 32'd4;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc       <= ResetVector;
            fetchDec <= '0;
        end
        else
        begin
            pc               <= pcSrc ? pcTarget : pcPlus4;   // redirect from execute
            fetchDec.pc      <= pc;
            fetchDec.pcPlus4 <= pcPlus4;
            fetchDec.instr   <= instr;
        end
    end

endmodule : fetchStage

`default_nettype wire

// ==== verilog/regFile.sv ====
/*
 * Register file, 32 x 32 bits. Written on the falling edge so that
 * decode reads a value written back in the same cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire cpuPkg::regAddrT rs1Addr,
    input  wire cpuPkg::regAddrT rs2Addr,
    input  wire cpuPkg::regAddrT rdAddr,
    input  wire logic            writeEn,
    input  wire cpuPkg::wordT    writeData,
    output cpuPkg::wordT         rs1Data,
    output cpuPkg::wordT         rs2Data
);

    cpuPkg::wordT regs [32];

    always_ff @(negedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEn)
        begin
            regs[rdAddr] <= writeData;
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];   // x0 reads zero
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule : regFile

`default_nettype wire

// ==== verilog/riscvCpu.sv ====
/*
 * Pipelined RV32I subset core. Connects fetch, decode, execute and
 * writeback stages with the register file; memories sit outside.
 */
`timescale 1ns/10ps
`default_nettype none

module riscvCpu #(
    parameter cpuPkg::wordT ResetVector = 32'h0040_0000
) (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire cpuPkg::wordT instr,
    input  wire cpuPkg::wordT readData,
    output cpuPkg::wordT      pc,
    output cpuPkg::wordT      aluResult,
    output cpuPkg::wordT      writeData,
    output logic              memWrite
);

    cpuPkg::fetchDecT fetchDec;
    cpuPkg::decExT    decEx;
    cpuPkg::exMemT    exMem;

    cpuPkg::regAddrT rs1Addr;
    cpuPkg::regAddrT rs2Addr;
    cpuPkg::wordT    rs1Data;
    cpuPkg::wordT    rs2Data;

    logic            pcSrc;
    cpuPkg::wordT    pcTarget;

    logic            regWrite;
    cpuPkg::regAddrT rdAddr;
    cpuPkg::wordT    result;

    fetchStage #(.ResetVector(ResetVector)) fetch (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget),
        .pc       (pc),
        .fetchDec (fetchDec)
    );

    decodeStage decode (
        .clk      (clk),
        .rst      (rst),
        .fetchDec (fetchDec),
        .rs1Addr  (rs1Addr),
        .rs2Addr  (rs2Addr),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .decEx    (decEx)
    );

    regFile regs (
        .clk       (clk),
        .rst       (rst),
        .rs1Addr   (rs1Addr),
        .rs2Addr   (rs2Addr),
        .rdAddr    (rdAddr),
        .writeEn   (regWrite),
        .writeData (result),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data)
    );

    executeStage execute (
        .clk      (clk),
        .rst      (rst),
        .decEx    (decEx),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget),
        .exMem    (exMem)
    );

    writebackStage writeback (
        .clk      (clk),
        .rst      (rst),
        .exMem    (exMem),
        .readData (readData),
        .regWrite (regWrite),
        .rdAddr   (rdAddr),
        .result   (result)
    );

    // data side comes straight from the memory stage
    assign aluResult = exMem.aluResult;
    assign writeData = exMem.writeData;
    assign memWrite  = exMem.memWrite;

endmodule : riscvCpu

`default_nettype wire

// ==== verilog/writebackStage.sv ====
/*
 * Writeback stage: memory-to-writeback register and result
 * selection between ALU result, load data and link address.
 */
`timescale 1ns/10ps
`default_nettype none

module writebackStage (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire cpuPkg::exMemT exMem,
    input  wire cpuPkg::wordT  readData,
    output logic               regWrite,
    output cpuPkg::regAddrT    rdAddr,
    output cpuPkg::wordT       result
);

    cpuPkg::memWbT memWb;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            memWb <= '0;
        end
        else
        begin
            memWb.regWrite  <= exMem.regWrite;
            memWb.resultSrc <= exMem.resultSrc;
            memWb.aluResult <= exMem.aluResult;
            memWb.readData  <= readData;   // load data from the memory stage
            memWb.rd        <= exMem.rd;
            memWb.pcPlus4   <= exMem.pcPlus4;
        end
    end

    always_comb
    begin
        case (memWb.resultSrc)
            cpuPkg::ResMem:     result = memWb.readData;
            cpuPkg::ResPcPlus4: result = memWb.pcPlus4;   // jal link
            default:            result = memWb.aluResult;
        endcase
    end

    assign regWrite = memWb.regWrite;
    assign rdAddr   = memWb.rd;

endmodule : writebackStage

`default_nettype wire
